// ==== hw/screen_pkg.sv ====
// Screen geometry package: visible area, boss hit box and coordinate width

`default_nettype none

package screen_pkg;

    // Every on-screen coordinate is an unsigned value of this width
    localparam int COORD_W = 12;

    // Visible area in pixels
    localparam int HOR_PIXELS = 1024;
    localparam int VER_PIXELS = 768;

    // Boss hit box half sizes around its centre point
    localparam int BOSS_LNG = 64;
    localparam int BOSS_HGT = 64;

endpackage

`default_nettype wire

// ==== hw/projectile_pkg.sv ====
// Projectile package: slot count, motion and timing constants, launcher states

`default_nettype none

package projectile_pkg;

    // Number of projectile slots and width of a slot index
    localparam int PROJECTILE_COUNT = 4;
    localparam int SLOT_IDX_W       = $clog2(PROJECTILE_COUNT);

    // Larger step component per frame, and the signed step width that holds it
    localparam int PROJECTILE_SPEED = 30;
    localparam int STEP_W           = 6;

    // Lifetime and cooldown are counted in frame ticks
    localparam int PROJECTILE_LIFETIME = 60;
    localparam int LIFETIME_W          = $clog2(PROJECTILE_LIFETIME + 1);
    localparam int FIRE_COOLDOWN       = 25;
    localparam int COOLDOWN_W          = $clog2(FIRE_COOLDOWN + 1);

    // Serial divider produces one quotient bit per cycle
    localparam int DIV_STEPS = 17;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    typedef enum logic [1:0] {
        LAUNCH_IDLE,
        LAUNCH_DIVIDE,
        LAUNCH_OFFER,
        LAUNCH_RELEASE
    } launch_state_t;

endpackage

`default_nettype wire

// ==== hw/projectile_launcher.sv ====
// Projectile launcher: fire gating, cooldown, slot choice, aimed step division and handoff

`timescale 1ns/1ps
`default_nettype none

module projectile_launcher (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire logic                                        frame_tick,
    input  wire logic                                        play,
    input  wire logic                                        fire,
    input  wire logic [screen_pkg::COORD_W-1:0]              mouse_x,
    input  wire logic [screen_pkg::COORD_W-1:0]              mouse_y,
    input  wire logic [screen_pkg::COORD_W-1:0]              spawn_x,
    input  wire logic [screen_pkg::COORD_W-1:0]              spawn_y,
    input  wire logic [projectile_pkg::PROJECTILE_COUNT-1:0] slot_active,
    input  wire logic [projectile_pkg::PROJECTILE_COUNT-1:0] launch_ack,
    output logic      [projectile_pkg::PROJECTILE_COUNT-1:0] launch_req,
    output logic      [screen_pkg::COORD_W-1:0]              launch_x,
    output logic      [screen_pkg::COORD_W-1:0]              launch_y,
    output logic signed [projectile_pkg::STEP_W-1:0]         launch_step_x,
    output logic signed [projectile_pkg::STEP_W-1:0]         launch_step_y
);
    import screen_pkg::*;
    import projectile_pkg::*;

    launch_state_t          state;
    logic [COOLDOWN_W-1:0]  cooldown;
    logic [SLOT_IDX_W-1:0]  sel_idx;
    logic [SLOT_IDX_W-1:0]  free_idx;
    logic                   any_free;
    logic                   accept;
    logic [DIV_CNT_W-1:0]   div_cnt;
    logic                   div_last;

    // Signed differences and their magnitudes at the click
    logic signed [COORD_W:0] dx;
    logic signed [COORD_W:0] dy;
    logic [COORD_W-1:0]      mag_x;
    logic [COORD_W-1:0]      mag_y;
    logic [COORD_W-1:0]      mag_max;

    // Divider state, the numerator register fills with quotient bits as it shifts
    logic [DIV_STEPS-1:0]    num_x;
    logic [DIV_STEPS-1:0]    num_y;
    logic [COORD_W-1:0]      rem_x;
    logic [COORD_W-1:0]      rem_y;
    logic [COORD_W-1:0]      divisor;
    logic                    neg_x;
    logic                    neg_y;
    logic                    zero_vec;
    logic [COORD_W:0]        div_x;
    logic [COORD_W:0]        div_y;

    // One restoring step, returns the new remainder above the quotient bit
    function automatic logic [COORD_W:0] div_step(
        input logic [COORD_W-1:0] rem,
        input logic               bit_in,
        input logic [COORD_W-1:0] dvs
    );
        logic [COORD_W:0] shifted;
        logic [COORD_W:0] diff;
        shifted = {rem, bit_in};
        diff    = shifted - {1'b0, dvs};
        if (shifted >= {1'b0, dvs}) begin
            return {diff[COORD_W-1:0], 1'b1};
        end
        return {shifted[COORD_W-1:0], 1'b0};
    endfunction

    // Quotient magnitude with the sign of the difference put back
    function automatic logic signed [STEP_W-1:0] signed_step(
        input logic [DIV_STEPS-1:0] quot,
        input logic                 neg,
        input logic                 zero
    );
        logic [STEP_W-1:0] mag;
        mag = quot[STEP_W-1:0];
        if (zero) begin
            return '0;
        end
        return neg ? -mag : mag;
    endfunction

    // Lowest inactive slot wins
    always_comb begin
        free_idx = '0;
        any_free = 1'b0;
        for (int i = PROJECTILE_COUNT - 1; i >= 0; i--) begin
            if (!slot_active[i]) begin
                free_idx = SLOT_IDX_W'(i);
                any_free = 1'b1;
            end
        end
    end

    always_comb begin
        dx      = $signed({1'b0, mouse_x}) - $signed({1'b0, spawn_x});
        dy      = $signed({1'b0, mouse_y}) - $signed({1'b0, spawn_y});
        mag_x   = dx[COORD_W] ? COORD_W'(-dx) : dx[COORD_W-1:0];
        mag_y   = dy[COORD_W] ? COORD_W'(-dy) : dy[COORD_W-1:0];
        mag_max = (mag_x > mag_y) ? mag_x : mag_y;
    end

    assign accept   = fire && play && (cooldown == '0) && (state == LAUNCH_IDLE) && any_free;
    assign div_last = (div_cnt == DIV_CNT_W'(DIV_STEPS - 1));
    assign div_x    = div_step(rem_x, num_x[DIV_STEPS-1], divisor);
    assign div_y    = div_step(rem_y, num_y[DIV_STEPS-1], divisor);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= LAUNCH_IDLE;
            cooldown   <= '0;
            sel_idx    <= '0;
            div_cnt    <= '0;
            launch_req <= '0;
        end else begin
            if (accept) begin
                cooldown <= COOLDOWN_W'(FIRE_COOLDOWN);
            end else if (frame_tick && cooldown != '0) begin
                cooldown <= cooldown - 1'b1;
            end

            case (state)
                LAUNCH_IDLE: begin
                    if (accept) begin
                        sel_idx <= free_idx;
                        div_cnt <= '0;
                        state   <= LAUNCH_DIVIDE;
                    end
                end
                LAUNCH_DIVIDE: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_last) begin
                        launch_req[sel_idx] <= 1'b1;
                        state               <= LAUNCH_OFFER;
                    end
                end
                LAUNCH_OFFER: begin
                    if (launch_ack[sel_idx]) begin
                        launch_req <= '0;
                        state      <= LAUNCH_RELEASE;
                    end
                end
                default: begin
                    // Wait for the slot to drop its ack
                    if (!launch_ack[sel_idx]) begin
                        state <= LAUNCH_IDLE;
                    end
                end
            endcase
        end
    end

    // Launch data and divider registers
    always_ff @(posedge clk) begin
        if (state == LAUNCH_IDLE && accept) begin
            launch_x <= spawn_x;
            launch_y <= spawn_y;
            num_x    <= DIV_STEPS'(mag_x) * DIV_STEPS'(PROJECTILE_SPEED);
            num_y    <= DIV_STEPS'(mag_y) * DIV_STEPS'(PROJECTILE_SPEED);
            rem_x    <= '0;
            rem_y    <= '0;
            divisor  <= mag_max;
            neg_x    <= dx[COORD_W];
            neg_y    <= dy[COORD_W];
            zero_vec <= (mag_max == '0);
        end else if (state == LAUNCH_DIVIDE) begin
            num_x <= {num_x[DIV_STEPS-2:0], div_x[0]};
            num_y <= {num_y[DIV_STEPS-2:0], div_y[0]};
            rem_x <= div_x[COORD_W:1];
            rem_y <= div_y[COORD_W:1];
            if (div_last) begin
                launch_step_x <= signed_step({num_x[DIV_STEPS-2:0], div_x[0]}, neg_x, zero_vec);
                launch_step_y <= signed_step({num_y[DIV_STEPS-2:0], div_y[0]}, neg_y, zero_vec);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/projectile_slot.sv ====
// Projectile slot: loads one launch, moves it per frame and retires it on expiry, bounds or hit

`timescale 1ns/1ps
`default_nettype none

module projectile_slot (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                frame_tick,
    input  wire logic                                play,
    input  wire logic                                launch_req,
    input  wire logic [screen_pkg::COORD_W-1:0]      launch_x,
    input  wire logic [screen_pkg::COORD_W-1:0]      launch_y,
    input  wire logic signed [projectile_pkg::STEP_W-1:0] launch_step_x,
    input  wire logic signed [projectile_pkg::STEP_W-1:0] launch_step_y,
    input  wire logic [screen_pkg::COORD_W-1:0]      boss_x,
    input  wire logic [screen_pkg::COORD_W-1:0]      boss_y,
    input  wire logic                                boss_alive,
    output logic                                     launch_ack,
    output logic [screen_pkg::COORD_W-1:0]           pos_x,
    output logic [screen_pkg::COORD_W-1:0]           pos_y,
    output logic                                     slot_active,
    output logic                                     slot_hit
);
    import screen_pkg::*;
    import projectile_pkg::*;

    logic signed [STEP_W-1:0] step_x;
    logic signed [STEP_W-1:0] step_y;
    logic [LIFETIME_W-1:0]    lifetime;
    logic                     load;
    logic                     retire;
    logic                     in_boss;

    assign load = launch_req && !launch_ack;

    // Out of bounds also catches positions that wrapped below zero
    assign retire = (lifetime == '0) ||
                    (pos_x > COORD_W'(HOR_PIXELS)) ||
                    (pos_y > COORD_W'(VER_PIXELS));

    // Box test in one extra bit so the edges near zero do not wrap
    assign in_boss = boss_alive &&
                     ({1'b0, pos_x} + (COORD_W+1)'(BOSS_LNG) >= {1'b0, boss_x}) &&
                     ({1'b0, pos_x} <= {1'b0, boss_x} + (COORD_W+1)'(BOSS_LNG)) &&
                     ({1'b0, pos_y} + (COORD_W+1)'(BOSS_HGT) >= {1'b0, boss_y}) &&
                     ({1'b0, pos_y} <= {1'b0, boss_y} + (COORD_W+1)'(BOSS_HGT));

    always_ff @(posedge clk) begin
        if (rst) begin
            launch_ack  <= 1'b0;
            slot_active <= 1'b0;
            slot_hit    <= 1'b0;
            pos_x       <= '0;
            pos_y       <= '0;
            lifetime    <= '0;
        end else begin
            slot_hit <= 1'b0;
            if (load) begin
                launch_ack  <= 1'b1;
                pos_x       <= launch_x;
                pos_y       <= launch_y;
                lifetime    <= LIFETIME_W'(PROJECTILE_LIFETIME);
                slot_active <= play;
            end else begin
                if (!launch_req) begin
                    launch_ack <= 1'b0;
                end
                if (!play) begin
                    slot_active <= 1'b0;
                end else if (frame_tick && slot_active) begin
                    if (retire) begin
                        slot_active <= 1'b0;
                    end else if (in_boss) begin
                        slot_active <= 1'b0;
                        slot_hit    <= 1'b1;
                    end else begin
                        // Motion wraps modulo the coordinate width
                        pos_x    <= pos_x + {{(COORD_W-STEP_W){step_x[STEP_W-1]}}, step_x};
                        pos_y    <= pos_y + {{(COORD_W-STEP_W){step_y[STEP_W-1]}}, step_y};
                        lifetime <= lifetime - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            step_x <= launch_step_x;
            step_y <= launch_step_y;
        end
    end

endmodule

`default_nettype wire

// ==== hw/hit_merge.sv ====
// Hit merger: one registered hit pulse and a running count of slot hits

`timescale 1ns/1ps
`default_nettype none

module hit_merge (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire logic [projectile_pkg::PROJECTILE_COUNT-1:0] slot_hit,
    output logic                                             projectile_hit,
    output logic [15:0]                                      hit_count
);
    import projectile_pkg::*;

    logic [15:0] hit_sum;

    // Several slots may hit in the same frame
    always_comb begin
        hit_sum = '0;
        for (int i = 0; i < PROJECTILE_COUNT; i++) begin
            hit_sum = hit_sum + 16'(slot_hit[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            projectile_hit <= 1'b0;
            hit_count      <= '0;
        end else begin
            projectile_hit <= |slot_hit;
            hit_count      <= hit_count + hit_sum;
        end
    end

endmodule

`default_nettype wire

// ==== hw/projectile_system.sv ====
// Projectile subsystem top: launcher, a bank of projectile slots and the hit merger

`timescale 1ns/1ps
`default_nettype none

module projectile_system (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   frame_tick,
    input  wire logic                                   play,
    input  wire logic                                   fire,
    input  wire logic [screen_pkg::COORD_W-1:0]         mouse_x,
    input  wire logic [screen_pkg::COORD_W-1:0]         mouse_y,
    input  wire logic [screen_pkg::COORD_W-1:0]         spawn_x,
    input  wire logic [screen_pkg::COORD_W-1:0]         spawn_y,
    input  wire logic [screen_pkg::COORD_W-1:0]         boss_x,
    input  wire logic [screen_pkg::COORD_W-1:0]         boss_y,
    input  wire logic                                   boss_alive,
    output logic [projectile_pkg::PROJECTILE_COUNT-1:0][screen_pkg::COORD_W-1:0] pos_x_proj,
    output logic [projectile_pkg::PROJECTILE_COUNT-1:0][screen_pkg::COORD_W-1:0] pos_y_proj,
    output logic [projectile_pkg::PROJECTILE_COUNT-1:0] pos_active,
    output logic                                        projectile_hit,
    output logic [15:0]                                 hit_count
);
    import screen_pkg::*;
    import projectile_pkg::*;

    logic [PROJECTILE_COUNT-1:0] launch_req;
    logic [PROJECTILE_COUNT-1:0] launch_ack;
    logic [PROJECTILE_COUNT-1:0] slot_hit;
    logic [COORD_W-1:0]          launch_x;
    logic [COORD_W-1:0]          launch_y;
    logic signed [STEP_W-1:0]    launch_step_x;
    logic signed [STEP_W-1:0]    launch_step_y;

    projectile_launcher projectile_launcher_i (
        .clk           (clk),
        .rst           (rst),
        .frame_tick    (frame_tick),
        .play          (play),
        .fire          (fire),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .spawn_x       (spawn_x),
        .spawn_y       (spawn_y),
        .slot_active   (pos_active),
        .launch_ack    (launch_ack),
        .launch_req    (launch_req),
        .launch_x      (launch_x),
        .launch_y      (launch_y),
        .launch_step_x (launch_step_x),
        .launch_step_y (launch_step_y)
    );

    for (genvar i = 0; i < PROJECTILE_COUNT; i++) begin : g_slot
        projectile_slot projectile_slot_i (
            .clk           (clk),
            .rst           (rst),
            .frame_tick    (frame_tick),
            .play          (play),
            .launch_req    (launch_req[i]),
            .launch_x      (launch_x),
            .launch_y      (launch_y),
            .launch_step_x (launch_step_x),
            .launch_step_y (launch_step_y),
            .boss_x        (boss_x),
            .boss_y        (boss_y),
            .boss_alive    (boss_alive),
            .launch_ack    (launch_ack[i]),
            .pos_x         (pos_x_proj[i]),
            .pos_y         (pos_y_proj[i]),
            .slot_active   (pos_active[i]),
            .slot_hit      (slot_hit[i])
        );
    end

    hit_merge hit_merge_i (
        .clk            (clk),
        .rst            (rst),
        .slot_hit       (slot_hit),
        .projectile_hit (projectile_hit),
        .hit_count      (hit_count)
    );

endmodule

`default_nettype wire

// ==== verification/projectile_system_tb.sv ====
// Projectile subsystem testbench for launches, cooldown, retirement, boss hits and play gating

`timescale 1ns/1ps
`default_nettype none

module projectile_system_tb;
    import screen_pkg::*;
    import projectile_pkg::*;

    localparam int TICK_PERIOD = 8;
    // Divider cycles plus the offer cycle between the accepting edge and the ack edge
    localparam int LAUNCH_LATENCY = DIV_STEPS + 1;
    localparam int SPAWN_X = 512;
    localparam int SPAWN_Y = 700;

    logic clk;
    logic rst;
    logic frame_tick;
    logic play;
    logic fire;
    logic [COORD_W-1:0] mouse_x;
    logic [COORD_W-1:0] mouse_y;
    logic [COORD_W-1:0] spawn_x;
    logic [COORD_W-1:0] spawn_y;
    logic [COORD_W-1:0] boss_x;
    logic [COORD_W-1:0] boss_y;
    logic boss_alive;
    logic [PROJECTILE_COUNT-1:0][COORD_W-1:0] pos_x_proj;
    logic [PROJECTILE_COUNT-1:0][COORD_W-1:0] pos_y_proj;
    logic [PROJECTILE_COUNT-1:0] pos_active;
    logic projectile_hit;
    logic [15:0] hit_count;

    // Expected state kept by the model
    logic [PROJECTILE_COUNT-1:0] exp_active;
    logic [COORD_W-1:0] exp_x [PROJECTILE_COUNT];
    logic [COORD_W-1:0] exp_y [PROJECTILE_COUNT];
    int exp_sx [PROJECTILE_COUNT];
    int exp_sy [PROJECTILE_COUNT];
    int exp_life [PROJECTILE_COUNT];
    int exp_cool;
    int exp_slot_hits;
    logic exp_proj_hit;
    logic [15:0] exp_count;
    int pend_cnt;
    int pend_slot;
    int pend_sx;
    int pend_sy;
    logic [COORD_W-1:0] pend_x;
    logic [COORD_W-1:0] pend_y;

    int tick_phase = 0;
    logic [31:0] lfsr = 32'h3aaa;

    projectile_system projectile_system_i (
        .clk            (clk),
        .rst            (rst),
        .frame_tick     (frame_tick),
        .play           (play),
        .fire           (fire),
        .mouse_x        (mouse_x),
        .mouse_y        (mouse_y),
        .spawn_x        (spawn_x),
        .spawn_y        (spawn_y),
        .boss_x         (boss_x),
        .boss_y         (boss_y),
        .boss_alive     (boss_alive),
        .pos_x_proj     (pos_x_proj),
        .pos_y_proj     (pos_y_proj),
        .pos_active     (pos_active),
        .projectile_hit (projectile_hit),
        .hit_count      (hit_count)
    );

    always #2 clk = ~clk;

    // One frame tick in every TICK_PERIOD cycles
    always @(posedge clk) begin
        #1;
        tick_phase = (tick_phase + 1) % TICK_PERIOD;
        frame_tick = (tick_phase == 0);
    end

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
            stop_run();
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // The larger magnitude maps to the speed and each component truncates toward zero
    function automatic int ref_step(input int d, input int other);
        int ad;
        int ao;
        int m;
        ad = (d < 0) ? -d : d;
        ao = (other < 0) ? -other : other;
        m = (ad > ao) ? ad : ao;
        if (m == 0) begin
            return 0;
        end
        return d * PROJECTILE_SPEED / m;
    endfunction

    function automatic int lowest_free(input logic [PROJECTILE_COUNT-1:0] act);
        for (int i = 0; i < PROJECTILE_COUNT; i++) begin
            if (!act[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic in_box(input int p, input int c, input int half);
        return (p >= c - half) && (p <= c + half);
    endfunction

    always @(posedge clk) begin : model
        int hits;
        int free_idx;
        int dx;
        int dy;
        logic accept;
        if (rst) begin
            exp_active = '0;
            exp_cool = 0;
            pend_cnt = -1;
            pend_slot = 0;
            exp_slot_hits = 0;
            exp_proj_hit = 1'b0;
            exp_count = '0;
        end else begin
            exp_proj_hit = (exp_slot_hits != 0);
            exp_count = exp_count + 16'(exp_slot_hits);
            free_idx = lowest_free(exp_active);
            accept = fire && play && (exp_cool == 0) && (pend_cnt < 0) && (free_idx >= 0);
            if (accept) begin
                dx = int'(mouse_x) - int'(spawn_x);
                dy = int'(mouse_y) - int'(spawn_y);
                exp_cool = FIRE_COOLDOWN;
                pend_cnt = LAUNCH_LATENCY;
                pend_slot = free_idx;
                pend_x = spawn_x;
                pend_y = spawn_y;
                pend_sx = ref_step(dx, dy);
                pend_sy = ref_step(dy, dx);
            end else if (frame_tick && exp_cool > 0) begin
                exp_cool--;
            end
            hits = 0;
            for (int i = 0; i < PROJECTILE_COUNT; i++) begin
                if (pend_cnt == 0 && pend_slot == i) begin
                    exp_active[i] = play;
                    exp_x[i] = pend_x;
                    exp_y[i] = pend_y;
                    exp_sx[i] = pend_sx;
                    exp_sy[i] = pend_sy;
                    exp_life[i] = PROJECTILE_LIFETIME;
                end else if (!play) begin
                    exp_active[i] = 1'b0;
                end else if (frame_tick && exp_active[i]) begin
                    if (exp_life[i] == 0 || exp_x[i] > HOR_PIXELS || exp_y[i] > VER_PIXELS) begin
                        exp_active[i] = 1'b0;
                    end else if (boss_alive && in_box(int'(exp_x[i]), int'(boss_x), BOSS_LNG) &&
                                 in_box(int'(exp_y[i]), int'(boss_y), BOSS_HGT)) begin
                        exp_active[i] = 1'b0;
                        hits++;
                    end else begin
                        exp_x[i] = exp_x[i] + COORD_W'(exp_sx[i]);
                        exp_y[i] = exp_y[i] + COORD_W'(exp_sy[i]);
                        exp_life[i]--;
                    end
                end
            end
            exp_slot_hits = hits;
            if (pend_cnt >= 0) begin
                pend_cnt--;
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check(32'(pos_active), 32'(exp_active), "pos_active");
            check(32'(projectile_hit), 32'(exp_proj_hit), "projectile_hit");
            check(32'(hit_count), 32'(exp_count), "hit_count");
            for (int i = 0; i < PROJECTILE_COUNT; i++) begin
                if (exp_active[i]) begin
                    check(32'(pos_x_proj[i]), 32'(exp_x[i]), $sformatf("slot %0d pos_x", i));
                    check(32'(pos_y_proj[i]), 32'(exp_y[i]), $sformatf("slot %0d pos_y", i));
                end
            end
        end
    end

    task automatic click(input int x, input int y);
        @(posedge clk);
        #1;
        mouse_x = COORD_W'(x);
        mouse_y = COORD_W'(y);
        fire = 1'b1;
        @(posedge clk);
        #1;
        fire = 1'b0;
    endtask

    task automatic wait_ticks(input int n);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < n && cycles < (n + 2) * TICK_PERIOD) begin
            @(posedge clk);
            cycles++;
            if (frame_tick) begin
                seen++;
            end
        end
        if (seen < n) begin
            $display("Timed out waiting for %0d frame ticks", n);
            stop_run();
        end
        @(negedge clk);
    endtask

    task automatic wait_cooldown();
        int cycles;
        cycles = 0;
        while (exp_cool != 0 && cycles < (FIRE_COOLDOWN + 2) * TICK_PERIOD) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_cool != 0) begin
            $display("Timed out waiting for the fire cooldown to run out");
            stop_run();
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (pos_active !== '0 && cycles < (PROJECTILE_LIFETIME + 4) * TICK_PERIOD) begin
            @(negedge clk);
            cycles++;
        end
        if (pos_active !== '0) begin
            $display("Timed out waiting for all projectiles to retire");
            stop_run();
        end
    endtask

    // Click, then wait for the slot the model chose to come up
    task automatic launch(input int x, input int y);
        int cycles;
        click(x, y);
        if (pend_cnt < 0) begin
            $display("A click that should start a projectile was not accepted");
            stop_run();
        end
        cycles = 0;
        while (pos_active[pend_slot] !== 1'b1 && cycles < LAUNCH_LATENCY + 8) begin
            @(negedge clk);
            cycles++;
        end
        if (pos_active[pend_slot] !== 1'b1) begin
            $display("Timed out waiting for slot %0d to start its projectile", pend_slot);
            stop_run();
        end
    endtask

    initial begin : scenario
        int tx;
        int ty;
        clk = 1'b0;
        rst = 1'b1;
        frame_tick = 1'b0;
        play = 1'b0;
        fire = 1'b0;
        mouse_x = '0;
        mouse_y = '0;
        spawn_x = COORD_W'(SPAWN_X);
        spawn_y = COORD_W'(SPAWN_Y);
        boss_x = COORD_W'(512);
        boss_y = COORD_W'(400);
        boss_alive = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        play = 1'b1;
        @(negedge clk);
        check(32'(pos_active), 0, "pos_active after reset");
        check(32'(projectile_hit), 0, "projectile_hit after reset");
        check(32'(hit_count), 0, "hit_count after reset");

        // Off-screen corner first, then random targets, then a zero step at the spawn
        launch(0, 0);
        for (int k = 0; k < 4; k++) begin
            tx = take_bits(10);
            ty = take_bits(9);
            wait_cooldown();
            launch(tx, ty);
        end
        wait_cooldown();
        launch(SPAWN_X, SPAWN_Y);
        wait_idle();

        // Cooldown blocks a quick second click and later clicks take the next slots
        launch(SPAWN_X, SPAWN_Y);
        wait_ticks(5);
        click(100, 100);
        wait_ticks(4);
        check(32'(pos_active), 32'b0001, "pos_active after a click in the cooldown");
        wait_cooldown();
        launch(SPAWN_X, SPAWN_Y);
        check(32'(pend_slot), 1, "slot after the cooldown");
        // With this cooldown and lifetime at most three projectiles live at once
        wait_cooldown();
        launch(SPAWN_X, SPAWN_Y);
        check(32'(pend_slot), 2, "third slot");
        wait_idle();

        // Straight up through the boss box
        @(posedge clk);
        #1;
        boss_alive = 1'b1;
        wait_cooldown();
        launch(SPAWN_X, 100);
        wait_idle();
        @(negedge clk);
        check(32'(hit_count), 1, "hit_count after a boss hit");
        @(posedge clk);
        #1;
        boss_alive = 1'b0;
        wait_cooldown();
        launch(SPAWN_X, 100);
        wait_idle();
        @(negedge clk);
        check(32'(hit_count), 1, "hit_count with the boss down");

        // Play low clears everything on the next clock and blocks firing
        wait_cooldown();
        launch(SPAWN_X, SPAWN_Y);
        wait_cooldown();
        launch(100, 100);
        @(posedge clk);
        #1;
        play = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check(32'(pos_active), 0, "pos_active after play low");
        wait_cooldown();
        click(SPAWN_X, SPAWN_Y);
        wait_ticks(3);
        check(32'(pos_active), 0, "pos_active after a click with play low");
        @(posedge clk);
        #1;
        play = 1'b1;
        // A click taken while play was low would have reloaded the cooldown
        launch(SPAWN_X, SPAWN_Y);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== projectile_system.f ====
hw/screen_pkg.sv
hw/projectile_pkg.sv
hw/projectile_launcher.sv
hw/projectile_slot.sv
hw/hit_merge.sv
hw/projectile_system.sv
verification/projectile_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the projectile subsystem testbench with Verilator and run it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    -f projectile_system.f \
    --top-module projectile_system_tb \
    --Mdir obj_dir \
    -o projectile_system_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/projectile_system_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
